//--- common/udp_tx_defines.svh
`ifndef UDP_TX_DEFINES_SVH
`define UDP_TX_DEFINES_SVH

// framing
`define PREAMBLE_LEN    7
`define PREAMBLE_BYTE   8'h55
`define SFD_BYTE        8'hD5
`define HDR_LEN         42          // eth 14 + ipv4 20 + udp 8

// smallest udp payload that fills a 60 byte frame
`define MIN_DATA_LEN    18

`define IFG_LEN         12          // cycles between frames

// protocol numbers
`define ETHERTYPE_IPV4  16'h0800
`define IP_PROTO_UDP    8'h11
`define IP_TTL          8'd64

// payload buffer, 2048 bytes
`define FIFO_DEPTH_LOG2 11

`endif

//--- common/udp_tx_pkg.sv
package udp_tx_pkg;

    // one octet on the wire or in the payload buffer
    typedef logic [7:0]  byte_t;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // payload, IP total or UDP length in bytes
    typedef logic [15:0] len_t;

    // everything the host supplies with a frame request
    typedef struct packed {
        mac_addr_t src_mac;
        mac_addr_t dst_mac;
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        len_t      data_len;    // udp payload bytes
    } frame_cfg_t;

    // wire sequencer states
    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        HEADER,
        PAYLOAD,
        PAD,        // zero fill up to the ethernet minimum
        FCS,
        GAP         // inter-frame gap
    } tx_state_e;

endpackage

//--- hw/payload_fifo.sv
`timescale 1ns/100ps
`include "udp_tx_defines.svh"

module payload_fifo #(
    parameter int DEPTH_LOG2 = `FIFO_DEPTH_LOG2
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              wr_en,
    input  udp_tx_pkg::byte_t wr_data,
    input  logic              rd_en,
    output udp_tx_pkg::byte_t rd_data,
    output logic              full,
    output logic              empty
);
    import udp_tx_pkg::*;

    localparam int DEPTH = 1 << DEPTH_LOG2;

    byte_t               mem [DEPTH];
    logic [DEPTH_LOG2:0] wr_ptr;    // extra msb tells full from empty
    logic [DEPTH_LOG2:0] rd_ptr;
    logic                do_wr;
    logic                do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                   (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

    assign do_wr = wr_en && !full;      // writes while full are lost
    assign do_rd = rd_en && !empty;

    // show-ahead output, head byte is always on rd_data
    assign rd_data = mem[rd_ptr[DEPTH_LOG2-1:0]];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- frame_tx/udp_ip_header.sv
`timescale 1ns/100ps
`include "udp_tx_defines.svh"

module udp_ip_header (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   load,
    input  udp_tx_pkg::frame_cfg_t cfg,
    input  logic [5:0]             idx,
    output udp_tx_pkg::byte_t      hdr_byte
);
    import udp_tx_pkg::*;

    frame_cfg_t            cfg_q;
    logic [15:0]           id_cnt;      // next identification number
    logic [15:0]           id_q;        // identification of the current frame
    len_t                  ip_len;
    len_t                  udp_len;
    logic [19:0]           sum;
    logic [16:0]           fold1;
    logic [15:0]           fold2;
    logic [15:0]           ip_chk;
    logic [`HDR_LEN*8-1:0] hdr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_cnt <= '0;
        end else if (load) begin
            id_cnt <= id_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cfg_q <= cfg;
            id_q  <= id_cnt;
        end
    end

    assign ip_len  = cfg_q.data_len + 16'd28;
    assign udp_len = cfg_q.data_len + 16'd8;

    // ten header words, checksum field counted as zero
    assign sum = 20'h04500
               + ip_len
               + id_q
               + 20'h04000
               + {`IP_TTL, `IP_PROTO_UDP}
               + cfg_q.src_ip[31:16]
               + cfg_q.src_ip[15:0]
               + cfg_q.dst_ip[31:16]
               + cfg_q.dst_ip[15:0];

    // end-around carry, the second fold cannot carry again
    assign fold1 = sum[15:0] + sum[19:16];
    assign fold2 = fold1[15:0] + fold1[16];

    // settles one cycle after load, long before byte 24 is needed
    always_ff @(posedge clk) begin
        ip_chk <= ~fold2;
    end

    assign hdr = {
        cfg_q.dst_mac,
        cfg_q.src_mac,
        `ETHERTYPE_IPV4,
        8'h45,                  // version 4, ihl 5
        8'h00,                  // tos
        ip_len,
        id_q,
        16'h4000,               // df set, offset 0
        `IP_TTL,
        `IP_PROTO_UDP,
        ip_chk,
        cfg_q.src_ip,
        cfg_q.dst_ip,
        cfg_q.src_port,
        cfg_q.dst_port,
        udp_len,
        16'h0000                // udp checksum unused
    };

    // byte 0 is the first on the wire
    always_comb begin
        if (idx < `HDR_LEN) begin
            hdr_byte = hdr[(`HDR_LEN - 1 - idx) * 8 +: 8];
        end else begin
            hdr_byte = '0;
        end
    end

endmodule

//--- frame_tx/frame_tx.sv
`timescale 1ns/100ps
`include "udp_tx_defines.svh"

module frame_tx (
    input  logic              clk,
    input  logic              arst_n,

    input  logic              fs,
    input  udp_tx_pkg::len_t  data_len,

    input  udp_tx_pkg::byte_t hdr_byte,
    input  udp_tx_pkg::byte_t fifo_data,
    input  logic [31:0]       crc,

    output logic              hdr_load,
    output logic [5:0]        hdr_idx,
    output logic              fifo_rd,
    output logic              crc_clr,
    output logic              crc_en,
    output udp_tx_pkg::byte_t crc_din,

    output udp_tx_pkg::byte_t txd,
    output logic              txen,
    output logic              tx_rdy,
    output logic              fd
);
    import udp_tx_pkg::*;

    tx_state_e state;
    len_t      cnt;         // byte index inside the current state
    len_t      len_q;
    byte_t     next_byte;
    logic      start;

    assign start    = fs && (state == IDLE);
    assign tx_rdy   = (state == IDLE);
    assign hdr_load = start;
    assign hdr_idx  = cnt[5:0];
    assign fifo_rd  = (state == PAYLOAD);   // show-ahead, byte is taken this cycle

    assign crc_clr  = (state == SFD);
    assign crc_en   = (state == HEADER) || (state == PAYLOAD) || (state == PAD);
    assign crc_din  = next_byte;

    // byte loaded into txd at the end of this cycle
    always_comb begin
        case (state)
            PREAMBLE: next_byte = `PREAMBLE_BYTE;
            SFD:      next_byte = `SFD_BYTE;
            HEADER:   next_byte = hdr_byte;
            PAYLOAD:  next_byte = fifo_data;
            FCS:      next_byte = ~crc[{cnt[1:0], 3'b000} +: 8];    // lsb first
            default:  next_byte = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin
            len_q <= data_len;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            cnt   <= '0;
            txd   <= '0;
            txen  <= 1'b0;
            fd    <= 1'b0;
        end else begin
            fd  <= 1'b0;
            txd <= next_byte;
            cnt <= cnt + 1'b1;
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (start) begin
                        txd   <= `PREAMBLE_BYTE;    // first preamble byte goes out now
                        txen  <= 1'b1;
                        cnt   <= 16'd1;
                        state <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    if (cnt == `PREAMBLE_LEN - 1) begin
                        state <= SFD;
                    end
                end
                SFD: begin
                    cnt   <= '0;
                    state <= HEADER;
                end
                HEADER: begin
                    if (cnt == `HDR_LEN - 1) begin
                        cnt   <= '0;
                        state <= (len_q == '0) ? PAD : PAYLOAD;
                    end
                end
                PAYLOAD: begin
                    if (cnt == len_q - 1'b1) begin
                        if (len_q < `MIN_DATA_LEN) begin
                            state <= PAD;   // cnt runs on to the minimum
                        end else begin
                            cnt   <= '0;
                            state <= FCS;
                        end
                    end
                end
                PAD: begin
                    if (cnt == `MIN_DATA_LEN - 1) begin
                        cnt   <= '0;
                        state <= FCS;
                    end
                end
                FCS: begin
                    // extra fifth cycle keeps the last fcs byte on the wire
                    if (cnt == 16'd4) begin
                        txd   <= '0;
                        txen  <= 1'b0;
                        fd    <= 1'b1;
                        cnt   <= '0;
                        state <= GAP;
                    end
                end
                GAP: begin
                    if (cnt == `IFG_LEN - 1) begin
                        cnt   <= '0;
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- frame_tx/crc32.sv
`timescale 1ns/100ps

module crc32 (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              clr,
    input  logic              en,
    input  udp_tx_pkg::byte_t din,
    output logic [31:0]       crc
);
    import udp_tx_pkg::*;

    localparam logic [31:0] POLY = 32'hEDB88320;     // 0x04C11DB7 bit reversed

    // shifts one byte in, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input byte_t d);
        logic [31:0] r;
        r = c ^ {24'h000000, d};
        for (int i = 0; i < 8; i++) begin
            if (r[0]) begin
                r = (r >> 1) ^ POLY;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crc <= '1;
        end else if (clr) begin
            crc <= '1;
        end else if (en) begin
            crc <= crc_byte(crc, din);
        end
    end

endmodule

//--- hw/mac_tx_top.sv
`timescale 1ns/100ps

module mac_tx_top (
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic                   wr_en,
    input  udp_tx_pkg::byte_t      wr_data,
    output logic                   fifo_full,

    input  logic                   fs,
    input  udp_tx_pkg::frame_cfg_t cfg,

    output udp_tx_pkg::byte_t      txd,
    output logic                   txen,
    output logic                   tx_rdy,
    output logic                   fd
);
    import udp_tx_pkg::*;

    logic        hdr_load;
    logic [5:0]  hdr_idx;
    byte_t       hdr_byte;
    logic        fifo_rd;
    byte_t       fifo_data;
    logic        crc_clr;
    logic        crc_en;
    byte_t       crc_din;
    logic [31:0] crc;

    payload_fifo
    payload_fifo_dut(
        .clk(clk),
        .arst_n(arst_n),
        .wr_en(wr_en),
        .wr_data(wr_data),
        .rd_en(fifo_rd),
        .rd_data(fifo_data),
        .full(fifo_full),
        .empty()
    );

    udp_ip_header
    udp_ip_header_dut(
        .clk(clk),
        .arst_n(arst_n),
        .load(hdr_load),
        .cfg(cfg),
        .idx(hdr_idx),
        .hdr_byte(hdr_byte)
    );

    frame_tx
    frame_tx_dut(
        .clk(clk),
        .arst_n(arst_n),
        .fs(fs),
        .data_len(cfg.data_len),
        .hdr_byte(hdr_byte),
        .fifo_data(fifo_data),
        .crc(crc),
        .hdr_load(hdr_load),
        .hdr_idx(hdr_idx),
        .fifo_rd(fifo_rd),
        .crc_clr(crc_clr),
        .crc_en(crc_en),
        .crc_din(crc_din),
        .txd(txd),
        .txen(txen),
        .tx_rdy(tx_rdy),
        .fd(fd)
    );

    crc32
    crc32_dut(
        .clk(clk),
        .arst_n(arst_n),
        .clr(crc_clr),
        .en(crc_en),
        .din(crc_din),
        .crc(crc)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

//--- test/mac_tx_assertions.sv
`timescale 1ns/100ps

module mac_tx_assertions (
    input logic                  clk,
    input logic                  arst_n,
    input udp_tx_pkg::tx_state_e state,
    input logic                  txen,
    input logic                  fd,
    input logic                  fs,
    input logic                  tx_rdy,
    input logic                  fifo_rd,
    input logic                  fifo_empty
);
    import udp_tx_pkg::*;

    int fail_count = 0;     // assertion failures so far

    txen_off_between_frames: assert property (@(posedge clk) disable iff (!arst_n)
        (state == IDLE || state == GAP) |-> !txen)
        else begin
            $error("txen high in IDLE or GAP");
            fail_count++;
        end

    fd_single_pulse: assert property (@(posedge clk) disable iff (!arst_n) fd |=> !fd)
        else begin
            $error("fd high for more than one cycle");
            fail_count++;
        end

    no_read_when_empty: assert property (@(posedge clk) disable iff (!arst_n)
        !(fifo_rd && fifo_empty))
        else begin
            $error("payload FIFO read while empty");
            fail_count++;
        end

    // a frame only starts from a request seen while ready
    start_needs_ready: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(txen) |-> $past(fs && tx_rdy))
        else begin
            $error("frame started without an accepted fs");
            fail_count++;
        end

endmodule

//--- test/mac_tx_tb.sv
`timescale 1ns/100ps
`include "udp_tx_defines.svh"

module mac_tx_tb;
    import udp_tx_pkg::*;

    localparam int FIFO_DEPTH     = 1 << `FIFO_DEPTH_LOG2;
    localparam int FRAME_CYCLES   = 6 * (8 + `HDR_LEN + 4) + 64 + `MIN_DATA_LEN + 30 + 20
                                  + 1472 + 576;
    localparam int GAP_CYCLES     = 6 * (`IFG_LEN + 1);
    localparam int FILL_WRITES    = 64 + 5 + 30 + 20 + 2100;
    localparam int TIMEOUT_CYCLES = 2 * (FRAME_CYCLES + GAP_CYCLES + FILL_WRITES);

    logic        clk;
    logic        arst_n;
    logic        wr_en;
    byte_t       wr_data;
    logic        fifo_full;
    logic        fs;
    frame_cfg_t  cfg;
    byte_t       txd;
    logic        txen;
    logic        tx_rdy;
    logic        fd;

    byte_t       sent_q[$];     // payload in the fifo, not framed yet
    byte_t       exp_q[$];      // model of the next frame on the wire
    byte_t       got_q[$];      // bytes seen while txen was high
    logic [15:0] next_id;
    int          cycles = 0;

    tb_clock clk_gen (.clk(clk));

    mac_tx_top UUT (
        .clk(clk),
        .arst_n(arst_n),
        .wr_en(wr_en),
        .wr_data(wr_data),
        .fifo_full(fifo_full),
        .fs(fs),
        .cfg(cfg),
        .txd(txd),
        .txen(txen),
        .tx_rdy(tx_rdy),
        .fd(fd)
    );

    bind mac_tx_top mac_tx_assertions sva (
        .clk(clk),
        .arst_n(arst_n),
        .state(frame_tx_dut.state),
        .txen(txen),
        .fd(fd),
        .fs(fs),
        .tx_rdy(tx_rdy),
        .fifo_rd(fifo_rd),
        .fifo_empty(payload_fifo_dut.empty)
    );

    always @(posedge clk) begin
        cycles++;
        if (UUT.sva.fail_count != 0) begin
            $display("an assertion on the DUT failed");
            $display("Some tests failed");
            $fatal(1, "assertion failure");
        end else if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // msb first, as the header fields go out
    function automatic void push_bytes(input logic [63:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            exp_q.push_back(v[i * 8 +: 8]);
        end
    endfunction

    function automatic logic [31:0] frame_fcs();
        logic [31:0] c;
        logic        fb;
        byte_t       d;
        c = 32'hFFFF_FFFF;
        for (int i = 8; i < exp_q.size(); i++) begin
            d = exp_q[i];
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ d[b];
                c  = {1'b0, c[31:1]} ^ (fb ? 32'hEDB8_8320 : 32'h0);
            end
        end
        return ~c;
    endfunction

    task automatic build_expected(input frame_cfg_t c);
        logic [31:0] sum;
        logic [31:0] fcs;
        exp_q.delete();
        repeat (`PREAMBLE_LEN) exp_q.push_back(`PREAMBLE_BYTE);
        exp_q.push_back(`SFD_BYTE);
        push_bytes(c.dst_mac, 6);
        push_bytes(c.src_mac, 6);
        push_bytes(`ETHERTYPE_IPV4, 2);
        push_bytes({8'h45, 8'h00, 16'(c.data_len + 16'd28)}, 4);
        push_bytes({next_id, 16'h4000, `IP_TTL, `IP_PROTO_UDP, 16'h0000}, 8);
        push_bytes(c.src_ip, 4);
        push_bytes(c.dst_ip, 4);
        sum = 0;
        for (int i = 22; i < 42; i += 2) begin
            sum += {exp_q[i], exp_q[i + 1]};
        end
        while (sum[31:16] != 0) begin
            sum = sum[15:0] + sum[31:16];
        end
        exp_q[32] = ~sum[15:8];
        exp_q[33] = ~sum[7:0];
        push_bytes({c.src_port, c.dst_port, 16'(c.data_len + 16'd8), 16'h0000}, 8);
        for (int i = 0; i < c.data_len; i++) begin
            exp_q.push_back(sent_q.pop_front());
        end
        for (int i = c.data_len; i < `MIN_DATA_LEN; i++) begin
            exp_q.push_back(8'h00);
        end
        fcs = frame_fcs();
        for (int i = 0; i < 4; i++) begin
            exp_q.push_back(fcs[i * 8 +: 8]);   // lsb first
        end
        next_id++;
    endtask

    function automatic frame_cfg_t random_cfg(input int len);
        frame_cfg_t c;
        c.src_mac  = {16'($urandom), $urandom};
        c.dst_mac  = {16'($urandom), $urandom};
        c.src_ip   = $urandom;
        c.dst_ip   = $urandom;
        c.src_port = 16'($urandom);
        c.dst_port = 16'($urandom);
        c.data_len = 16'(len);
        return c;
    endfunction

    task automatic write_payload(input int n);
        for (int i = 0; i < n; i++) begin
            wr_en   = 1'b1;
            wr_data = 8'($urandom);
            sent_q.push_back(wr_data);
            step();
        end
        wr_en = 1'b0;
    endtask

    // requests one frame and follows it through fd and the gap
    task automatic send_frame(input frame_cfg_t c, input bit extra_fs);
        int body;
        int gap;
        body = (c.data_len < `MIN_DATA_LEN) ? `MIN_DATA_LEN : c.data_len;
        build_expected(c);
        while (!tx_rdy) begin
            step();
        end
        cfg = c;
        fs  = 1'b1;
        step();
        fs  = 1'b0;
        check(tx_rdy, 1'b0, "tx_rdy after accepted fs");
        got_q.delete();
        while (txen) begin
            got_q.push_back(txd);
            fs = extra_fs && (got_q.size() == 20);  // must be ignored mid frame
            step();
        end
        fs = 1'b0;
        check(got_q.size(), 8 + `HDR_LEN + body + 4, "txen cycles");
        for (int i = 0; i < exp_q.size(); i++) begin
            check(got_q[i], exp_q[i], $sformatf("frame byte %0d", i));
        end
        check(fd, 1'b1, "fd after the last fcs byte");
        gap = 0;
        while (!tx_rdy) begin
            step();
            gap++;
            check(fd, 1'b0, "fd longer than one cycle");
            check(txen, 1'b0, "txen during the gap");
        end
        check(gap, `IFG_LEN, "cycles from fd to tx_rdy");
    endtask

    task automatic reset_state();
        check(txen, 1'b0, "txen after reset");
        check(fd, 1'b0, "fd after reset");
        check(fifo_full, 1'b0, "fifo_full after reset");
        check(tx_rdy, 1'b1, "tx_rdy after reset");
        check(txd, 8'h00, "txd after reset");
    endtask

    task automatic standard_frame();
        write_payload(64);
        send_frame(random_cfg(64), 1'b0);
        check(got_q.size(), 118, "standard frame length");
    endtask

    task automatic short_frame();
        write_payload(5);
        send_frame(random_cfg(5), 1'b0);
        check({got_q[24], got_q[25]}, 33, "ip total length");
        check({got_q[46], got_q[47]}, 13, "udp length");
        for (int i = 55; i < 68; i++) begin
            check(got_q[i], 8'h00, $sformatf("pad byte %0d", i));
        end
        check(got_q.size(), 72, "short frame length");
        for (int i = 68; i < 72; i++) begin
            check(got_q[i], exp_q[i], "short frame fcs");
        end
    endtask

    task automatic back_to_back();
        frame_cfg_t  first;
        frame_cfg_t  second;
        logic [15:0] first_id;
        first  = random_cfg(30);
        second = random_cfg(20);
        write_payload(30);
        write_payload(20);
        send_frame(first, 1'b1);
        first_id = {got_q[26], got_q[27]};
        send_frame(second, 1'b0);
        check({got_q[26], got_q[27]}, 16'(first_id + 16'd1), "second frame identification");
    endtask

    task automatic fifo_limit();
        for (int i = 0; i < 2100; i++) begin
            check(fifo_full, i >= FIFO_DEPTH, $sformatf("fifo_full before write %0d", i));
            wr_en   = 1'b1;
            wr_data = 8'($urandom);
            if (i < FIFO_DEPTH) begin
                sent_q.push_back(wr_data);      // later bytes are dropped
            end
            step();
        end
        wr_en = 1'b0;
        check(fifo_full, 1'b1, "fifo_full after overfill");
        send_frame(random_cfg(1472), 1'b0);
        check(fifo_full, 1'b0, "fifo_full after a 1472 byte frame");
        send_frame(random_cfg(576), 1'b0);
    endtask

    initial begin
        void'($urandom(32'h8034_8068));
        arst_n  = 1'b0;
        wr_en   = 1'b0;
        wr_data = '0;
        fs      = 1'b0;
        cfg     = '0;
        next_id = 16'h0000;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        step();
        reset_state();
        standard_frame();
        short_frame();
        back_to_back();
        fifo_limit();
        if (UUT.sva.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("%0d assertion failures", UUT.sva.fail_count);
            $display("Some tests failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- sim.f
+incdir+common
common/udp_tx_pkg.sv
hw/payload_fifo.sv
frame_tx/udp_ip_header.sv
frame_tx/frame_tx.sv
frame_tx/crc32.sv
hw/mac_tx_top.sv
test/tb_clock.sv
test/mac_tx_assertions.sv
test/mac_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mac_tx_tb -f sim.f \
    -o mac_tx_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/mac_tx_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
grep -q "All tests passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
